/* rtl/rsPkg.sv */
package rsPkg;

    // Reservation station geometry
    localparam int rsSize = 6;
    localparam int idxWidth = 3;

    // Number of rows in the lowest-set-bit lookup, one per status pattern
    localparam int tableSize = 2 ** rsSize;

    // Index code returned when no status bit is set
    localparam logic [idxWidth-1:0] noReady = 3'd7;

    // Producer tags. Tag 0 marks an operand that already holds its value,
    // so a valid result never carries it
    localparam int tagWidth = 4;
    localparam logic [tagWidth-1:0] readyTag = '0;

    // Operand and result width
    localparam int dataWidth = 32;

    // Shift amounts come from the low bits of operand B
    localparam int shiftWidth = 5;

    // ALU operation codes
    localparam int opWidth = 3;

    typedef enum logic [opWidth-1:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opAnd = 3'd2,
        opOr  = 3'd3,
        opXor = 3'd4,
        opSll = 3'd5,
        opSrl = 3'd6,
        opSlt = 3'd7
    } aluOp_e;

endpackage

/* rtl/rdyList.sv */
`timescale 1ns/1ps

module rdyList (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rsPkg::rsSize-1:0]   readyStatus,
    output logic [rsPkg::idxWidth-1:0] readyALU
);

    logic [rsPkg::idxWidth-1:0] lookup [rsPkg::tableSize];

    // Position of the lowest set bit, scanning down so the last hit wins
    function automatic logic [rsPkg::idxWidth-1:0] lowestSet(
        input logic [rsPkg::rsSize-1:0] pattern
    );
        logic [rsPkg::idxWidth-1:0] code;
        code = rsPkg::noReady;
        for (int b = rsPkg::rsSize - 1; b >= 0; b--) begin
            if (pattern[b]) begin
                code = b[rsPkg::idxWidth-1:0];
            end
        end
        return code;
    endfunction

    // Contents are rebuilt on every reset edge and held afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < rsPkg::tableSize; a++) begin
                lookup[a] <= lowestSet(a[rsPkg::rsSize-1:0]);
            end
        end
    end

    assign readyALU = lookup[readyStatus];

endmodule

/* rtl/rsEntryBank.sv */
`timescale 1ns/1ps

module rsEntryBank (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        dispatchValid,
    input  rsPkg::aluOp_e               dispatchOp,
    input  logic [rsPkg::tagWidth-1:0]  dispatchTagA,
    input  logic [rsPkg::dataWidth-1:0] dispatchDataA,
    input  logic [rsPkg::tagWidth-1:0]  dispatchTagB,
    input  logic [rsPkg::dataWidth-1:0] dispatchDataB,
    input  logic [rsPkg::tagWidth-1:0]  dispatchDest,
    input  logic [rsPkg::idxWidth-1:0]  allocIdx,
    input  logic [rsPkg::idxWidth-1:0]  issueIdx,

    input  logic                        extValid,
    input  logic [rsPkg::tagWidth-1:0]  extTag,
    input  logic [rsPkg::dataWidth-1:0] extData,
    input  logic                        resultValid,
    input  logic [rsPkg::tagWidth-1:0]  resultTag,
    input  logic [rsPkg::dataWidth-1:0] resultData,

    output logic [rsPkg::rsSize-1:0]    readyBits,
    output logic [rsPkg::rsSize-1:0]    freeBits,
    output rsPkg::aluOp_e               issueOp,
    output logic [rsPkg::dataWidth-1:0] issueA,
    output logic [rsPkg::dataWidth-1:0] issueB,
    output logic [rsPkg::tagWidth-1:0]  issueDest,
    output logic                        issueValid
);

    logic [rsPkg::rsSize-1:0]    entryValid;
    rsPkg::aluOp_e               entryOp    [rsPkg::rsSize];
    logic [rsPkg::tagWidth-1:0]  entryTagA  [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] entryDataA [rsPkg::rsSize];
    logic [rsPkg::tagWidth-1:0]  entryTagB  [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] entryDataB [rsPkg::rsSize];
    logic [rsPkg::tagWidth-1:0]  entryDest  [rsPkg::rsSize];

    logic [rsPkg::tagWidth-1:0]  newTagA;
    logic [rsPkg::dataWidth-1:0] newDataA;
    logic [rsPkg::tagWidth-1:0]  newTagB;
    logic [rsPkg::dataWidth-1:0] newDataB;
    logic [rsPkg::idxWidth-1:0]  issueSel;
    logic                        doDispatch;

    // A waiting tag matches when either bus broadcasts it this cycle
    function automatic logic busHit(input logic [rsPkg::tagWidth-1:0] tag);
        logic extHit;
        logic aluHit;
        extHit = extValid && (extTag == tag);
        aluHit = resultValid && (resultTag == tag);
        return (tag != rsPkg::readyTag) && (extHit || aluHit);
    endfunction

    // Tags are unique in flight, so at most one bus can match
    function automatic logic [rsPkg::dataWidth-1:0] busData(
        input logic [rsPkg::tagWidth-1:0] tag
    );
        logic [rsPkg::dataWidth-1:0] value;
        value = resultData;
        if (extValid && (extTag == tag)) begin
            value = extData;
        end
        return value;
    endfunction

    // Dispatched operands can be satisfied by a broadcast in the same cycle
    always_comb begin
        newTagA  = dispatchTagA;
        newDataA = dispatchDataA;
        newTagB  = dispatchTagB;
        newDataB = dispatchDataB;
        if (busHit(dispatchTagA)) begin
            newTagA  = rsPkg::readyTag;
            newDataA = busData(dispatchTagA);
        end
        if (busHit(dispatchTagB)) begin
            newTagB  = rsPkg::readyTag;
            newDataB = busData(dispatchTagB);
        end
    end

    assign doDispatch = dispatchValid && (allocIdx != rsPkg::noReady);
    assign issueValid = (issueIdx != rsPkg::noReady);

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else begin
            if (issueValid) begin
                entryValid[issueIdx] <= 1'b0;
            end
            if (doDispatch) begin
                entryValid[allocIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            if (entryValid[i] && busHit(entryTagA[i])) begin
                entryTagA[i]  <= rsPkg::readyTag;
                entryDataA[i] <= busData(entryTagA[i]);
            end
            if (entryValid[i] && busHit(entryTagB[i])) begin
                entryTagB[i]  <= rsPkg::readyTag;
                entryDataB[i] <= busData(entryTagB[i]);
            end
        end
        // The target slot is free, so this never collides with snooping above
        if (doDispatch) begin
            entryOp[allocIdx]    <= dispatchOp;
            entryTagA[allocIdx]  <= newTagA;
            entryDataA[allocIdx] <= newDataA;
            entryTagB[allocIdx]  <= newTagB;
            entryDataB[allocIdx] <= newDataB;
            entryDest[allocIdx]  <= dispatchDest;
        end
    end

    always_comb begin
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            readyBits[i] = entryValid[i]
                && (entryTagA[i] == rsPkg::readyTag)
                && (entryTagB[i] == rsPkg::readyTag);
        end
    end

    assign freeBits = ~entryValid;

    // Keep the read index in range when nothing issues
    assign issueSel  = issueValid ? issueIdx : '0;
    assign issueOp   = entryOp[issueSel];
    assign issueA    = entryDataA[issueSel];
    assign issueB    = entryDataB[issueSel];
    assign issueDest = entryDest[issueSel];

endmodule

/* rtl/aluExec.sv */
`timescale 1ns/1ps

module aluExec (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  rsPkg::aluOp_e               issueOp,
    input  logic [rsPkg::dataWidth-1:0] issueA,
    input  logic [rsPkg::dataWidth-1:0] issueB,
    input  logic [rsPkg::tagWidth-1:0]  issueDest,
    output logic                        resultValid,
    output logic [rsPkg::tagWidth-1:0]  resultTag,
    output logic [rsPkg::dataWidth-1:0] resultData
);

    logic [rsPkg::dataWidth-1:0]  aluOut;
    logic [rsPkg::shiftWidth-1:0] shamt;

    assign shamt = issueB[rsPkg::shiftWidth-1:0];

    always_comb begin
        aluOut = '0;
        case (issueOp)
            rsPkg::opAdd: aluOut = issueA + issueB;
            rsPkg::opSub: aluOut = issueA - issueB;
            rsPkg::opAnd: aluOut = issueA & issueB;
            rsPkg::opOr:  aluOut = issueA | issueB;
            rsPkg::opXor: aluOut = issueA ^ issueB;
            rsPkg::opSll: aluOut = issueA << shamt;
            rsPkg::opSrl: aluOut = issueA >> shamt;
            // Signed compare, result is 1 or 0
            rsPkg::opSlt: begin
                if ($signed(issueA) < $signed(issueB)) begin
                    aluOut = 32'd1;
                end
            end
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= issueValid;
        end
    end

    // Tag and data only move on an issue, valid qualifies them
    always_ff @(posedge clk) begin
        if (issueValid) begin
            resultTag  <= issueDest;
            resultData <= aluOut;
        end
    end

endmodule

/* rtl/aluCluster.sv */
`timescale 1ns/1ps

module aluCluster (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        dispatchValid,
    input  rsPkg::aluOp_e               dispatchOp,
    input  logic [rsPkg::tagWidth-1:0]  dispatchTagA,
    input  logic [rsPkg::dataWidth-1:0] dispatchDataA,
    input  logic [rsPkg::tagWidth-1:0]  dispatchTagB,
    input  logic [rsPkg::dataWidth-1:0] dispatchDataB,
    input  logic [rsPkg::tagWidth-1:0]  dispatchDest,

    input  logic                        extValid,
    input  logic [rsPkg::tagWidth-1:0]  extTag,
    input  logic [rsPkg::dataWidth-1:0] extData,

    output logic                        full,
    output logic                        resultValid,
    output logic [rsPkg::tagWidth-1:0]  resultTag,
    output logic [rsPkg::dataWidth-1:0] resultData
);

    logic [rsPkg::rsSize-1:0]    readyBits;
    logic [rsPkg::rsSize-1:0]    freeBits;
    logic [rsPkg::idxWidth-1:0]  issueIdx;
    logic [rsPkg::idxWidth-1:0]  allocIdx;
    rsPkg::aluOp_e               issueOp;
    logic [rsPkg::dataWidth-1:0] issueA;
    logic [rsPkg::dataWidth-1:0] issueB;
    logic [rsPkg::tagWidth-1:0]  issueDest;
    logic                        issueValid;

    rsEntryBank entryBank (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchOp    (dispatchOp),
        .dispatchTagA  (dispatchTagA),
        .dispatchDataA (dispatchDataA),
        .dispatchTagB  (dispatchTagB),
        .dispatchDataB (dispatchDataB),
        .dispatchDest  (dispatchDest),
        .allocIdx      (allocIdx),
        .issueIdx      (issueIdx),
        .extValid      (extValid),
        .extTag        (extTag),
        .extData       (extData),
        .resultValid   (resultValid),
        .resultTag     (resultTag),
        .resultData    (resultData),
        .readyBits     (readyBits),
        .freeBits      (freeBits),
        .issueOp       (issueOp),
        .issueA        (issueA),
        .issueB        (issueB),
        .issueDest     (issueDest),
        .issueValid    (issueValid)
    );

    // Lowest ready entry goes to the ALU
    rdyList readySel (
        .clk         (clk),
        .rst         (rst),
        .readyStatus (readyBits),
        .readyALU    (issueIdx)
    );

    // Lowest free entry takes the next dispatch
    rdyList freeSel (
        .clk         (clk),
        .rst         (rst),
        .readyStatus (freeBits),
        .readyALU    (allocIdx)
    );

    aluExec alu (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueA      (issueA),
        .issueB      (issueB),
        .issueDest   (issueDest),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultData  (resultData)
    );

    assign full = (allocIdx == rsPkg::noReady);

endmodule

/* dv/aluCluster_checker.sv */
`timescale 1ns/1ps

module aluCluster_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       dispatchValid,
    input logic [rsPkg::tagWidth-1:0] dispatchTagA,
    input logic [rsPkg::tagWidth-1:0] dispatchTagB,
    input logic [rsPkg::rsSize-1:0]   freeBits,
    input logic                       full,
    input logic                       resultValid,
    input logic [rsPkg::tagWidth-1:0] resultTag
);

    // The ALU pipeline is empty right after reset
    resultClearAfterReset: assert property (@(posedge clk) $fell(rst) |-> !resultValid)
        else $error("resultValid high in the cycle after reset");

    // Dispatching into a full station would overwrite nothing and lose the op
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        dispatchValid |-> !full)
        else $error("dispatch while the station is full");

    resultTagNonZero: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> (resultTag != '0))
        else $error("result broadcast with tag 0");

    // A ready op into an empty station issues next cycle and retires one later
    readyOpLatency: assert property (@(posedge clk) disable iff (rst)
        (dispatchValid && (dispatchTagA == '0) && (dispatchTagB == '0) && (&freeBits))
        |-> ##2 resultValid)
        else $error("ready dispatch into an empty station gave no result 2 cycles later");

endmodule

bind aluCluster aluCluster_checker portCheck (
    .clk           (clk),
    .rst           (rst),
    .dispatchValid (dispatchValid),
    .dispatchTagA  (dispatchTagA),
    .dispatchTagB  (dispatchTagB),
    .freeBits      (freeBits),
    .full          (full),
    .resultValid   (resultValid),
    .resultTag     (resultTag)
);

/* dv/aluClusterTb.sv */
`timescale 1ns/1ps

module aluClusterTb;

    localparam int cycleLimit = 400;
    localparam int clkPeriod = 100;

    logic                        clk;
    logic                        rst;
    logic                        dispatchValid;
    rsPkg::aluOp_e               dispatchOp;
    logic [rsPkg::tagWidth-1:0]  dispatchTagA;
    logic [rsPkg::dataWidth-1:0] dispatchDataA;
    logic [rsPkg::tagWidth-1:0]  dispatchTagB;
    logic [rsPkg::dataWidth-1:0] dispatchDataB;
    logic [rsPkg::tagWidth-1:0]  dispatchDest;
    logic                        extValid;
    logic [rsPkg::tagWidth-1:0]  extTag;
    logic [rsPkg::dataWidth-1:0] extData;
    logic                        full;
    logic                        resultValid;
    logic [rsPkg::tagWidth-1:0]  resultTag;
    logic [rsPkg::dataWidth-1:0] resultData;

    logic [31:0] rngState;
    logic [31:0] knownValue   [16];
    logic [31:0] expectedData [16];
    bit          pendingTag   [16];
    int          pendingCount;
    int          cycleCount;
    time         broadcastTime;
    int          seenTags     [$];
    time         seenTimes    [$];

    aluCluster DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Reference ALU written from the operation definitions
    function automatic logic [31:0] modelResult(rsPkg::aluOp_e op, logic [31:0] a,
                                                logic [31:0] b);
        case (op)
            rsPkg::opAdd: return a + b;
            rsPkg::opSub: return a - b;
            rsPkg::opAnd: return a & b;
            rsPkg::opOr:  return a | b;
            rsPkg::opXor: return a ^ b;
            rsPkg::opSll: return a << b[4:0];
            rsPkg::opSrl: return a >> b[4:0];
            default:      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic failNow(input string msg);
        $display("[ERROR] %0d ns %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // Operands with a nonzero tag take the value that tag will broadcast
    task automatic dispatch(rsPkg::aluOp_e op, logic [3:0] tagA, logic [31:0] dataA,
                            logic [3:0] tagB, logic [31:0] dataB, logic [3:0] dest);
        logic [31:0] a;
        logic [31:0] b;
        a = (tagA != 4'd0) ? knownValue[tagA] : dataA;
        b = (tagB != 4'd0) ? knownValue[tagB] : dataB;
        @(posedge clk);
        dispatchValid <= 1'b1;
        dispatchOp    <= op;
        dispatchTagA  <= tagA;
        dispatchDataA <= dataA;
        dispatchTagB  <= tagB;
        dispatchDataB <= dataB;
        dispatchDest  <= dest;
        expectedData[dest] = modelResult(op, a, b);
        knownValue[dest]   = expectedData[dest];
        pendingTag[dest]   = 1'b1;
        pendingCount++;
    endtask

    task automatic endDispatch();
        @(posedge clk);
        dispatchValid <= 1'b0;
    endtask

    // broadcastTime is the edge where the station samples the bus
    task automatic broadcast(logic [3:0] tag);
        @(posedge clk);
        extValid <= 1'b1;
        extTag   <= tag;
        extData  <= knownValue[tag];
        @(posedge clk);
        broadcastTime = $time;
        extValid <= 1'b0;
    endtask

    task automatic waitIdle();
        while (pendingCount != 0) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && resultValid) begin
            assert (pendingTag[resultTag])
                else failNow($sformatf("result with unexpected tag %0d", resultTag));
            assert (resultData == expectedData[resultTag])
                else failNow($sformatf("tag %0d gave %h, expected %h", resultTag,
                                       resultData, expectedData[resultTag]));
            pendingTag[resultTag] = 1'b0;
            pendingCount--;
            seenTags.push_back(int'(resultTag));
            seenTimes.push_back($time);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $fatal(1);
        end
    end

    initial begin
        logic [3:0] tagA;
        logic [3:0] tagB;
        int n;
        int mode;
        rngState = 32'h11a370bc;
        pendingCount = 0;
        cycleCount = 0;
        broadcastTime = 0;
        for (int i = 0; i < 16; i++) begin
            pendingTag[i] = 1'b0;
            knownValue[i] = '0;
            expectedData[i] = '0;
        end
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchOp = rsPkg::opAdd;
        dispatchTagA = '0;
        dispatchDataA = '0;
        dispatchTagB = '0;
        dispatchDataB = '0;
        dispatchDest = '0;
        extValid = 1'b0;
        extTag = '0;
        extData = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!full && !resultValid) else failNow("full or resultValid high after reset");

        // Every operation with ready operands
        for (int op = 0; op < 8; op++) begin
            dispatch(rsPkg::aluOp_e'(op[2:0]), 4'd0, nextRandom(), 4'd0, nextRandom(), 4'd3);
            endDispatch();
            waitIdle();
        end

        // Operand B waits on an external producer
        knownValue[12] = nextRandom();
        seenTags.delete();
        seenTimes.delete();
        dispatch(rsPkg::opXor, 4'd0, nextRandom(), 4'd12, 32'd0, 4'd1);
        endDispatch();
        broadcast(4'd12);
        waitIdle();
        assert (seenTimes.size() == 1 && seenTimes[0] == broadcastTime + 2 * clkPeriod)
            else failNow("external operand result did not follow the broadcast by 2 cycles");

        // Second op consumes the first op's result off the ALU bus
        dispatch(rsPkg::opAdd, 4'd0, nextRandom(), 4'd0, nextRandom(), 4'd1);
        dispatch(rsPkg::opSub, 4'd1, 32'd0, 4'd0, nextRandom(), 4'd2);
        endDispatch();
        waitIdle();

        // Fill all six entries behind one external tag
        knownValue[9] = nextRandom();
        for (int k = 1; k <= 6; k++) begin
            dispatch(rsPkg::opOr, 4'd9, 32'd0, 4'd0, nextRandom(), 4'(k));
        end
        endDispatch();
        @(posedge clk);
        assert (full) else failNow("full did not rise with six entries");
        seenTags.delete();
        seenTimes.delete();
        broadcast(4'd9);
        waitIdle();
        for (int k = 0; k < 6; k++) begin
            assert (seenTags[k] == k + 1
                    && seenTimes[k] == broadcastTime + (k + 2) * clkPeriod)
                else failNow("drain was not one result per cycle in entry order");
        end
        @(posedge clk);
        assert (!full) else failNow("full stayed high after the station drained");
        dispatch(rsPkg::opAnd, 4'd0, nextRandom(), 4'd0, nextRandom(), 4'd4);
        endDispatch();
        waitIdle();

        // Random groups mixing ready, external and chained operands
        for (int g = 0; g < 10; g++) begin
            knownValue[15] = nextRandom();
            n = 1 + int'(nextRandom() % 4);
            for (int k = 0; k < n; k++) begin
                mode = int'(nextRandom() % 3);
                tagA = 4'd0;
                tagB = 4'd0;
                if (mode == 1) begin
                    tagA = 4'd15;
                end else if (mode == 2 && k > 0) begin
                    tagB = 4'(k);
                end
                dispatch(rsPkg::aluOp_e'(nextRandom() % 8), tagA, nextRandom(),
                         tagB, nextRandom(), 4'(k + 1));
            end
            endDispatch();
            broadcast(4'd15);
            waitIdle();
        end

        @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

/* project.f */
rtl/rsPkg.sv
rtl/rdyList.sv
rtl/rsEntryBank.sv
rtl/aluExec.sv
rtl/aluCluster.sv
dv/aluCluster_checker.sv
dv/aluClusterTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = aluClusterTb
FILELIST = project.f
PASS     = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the testbench prints the pass message
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
